//--- source/decodePkg.sv
// decode package
// shared types, internal register codes and micro-op encodings for the
// rv32 decode stage, plus instruction field positions
`default_nettype none

package decodePkg;

	typedef logic [31:0] instrWordT;
	typedef logic [7:0] regIdT;
	// bit 32 is the extension sign
	typedef logic [32:0] immT;

	// general registers sit at 0x00-0x1F, these are the ones named directly
	localparam regIdT regR2 = 8'h02;
	localparam regIdT regR3 = 8'h03;

	// special registers
	localparam regIdT regZzr = 8'h20;
	localparam regIdT regLr = 8'h21;
	localparam regIdT regSp = 8'h22;
	localparam regIdT regGbr = 8'h23;
	localparam regIdT regTbr = 8'h24;
	localparam regIdT regDhr = 8'h25;
	localparam regIdT regBpc = 8'h26;
	localparam regIdT regImm = 8'h27;

	// control registers, low six csr bits added on top
	localparam regIdT regCrBase = 8'h40;

	typedef enum logic [5:0] {
		cmdInvOp,
		cmdAlu3,
		cmdShad3,
		cmdMulDiv,
		cmdMovMr,
		cmdMovRm,
		cmdJcmp,
		cmdJsr,
		cmdJmp,
		cmdLeaMr,
		cmdMovIr,
		cmdMovRc,
		cmdMovCr,
		cmdOpIxt
	} uCmdT;

	// loads and stores reuse this field for funct3
	typedef enum logic [5:0] {
		ixtAdd, ixtSub, ixtSltS, ixtSltU, ixtXor, ixtOr, ixtAnd,
		ixtShl, ixtShlr, ixtShar,
		ixtMul, ixtMulhs, ixtMulhsu, ixtMulhu,
		ixtDivs, ixtDivu, ixtMods, ixtModu,
		ixtEq, ixtNe, ixtLt, ixtGe, ixtBl, ixtHs,
		ixtSyse, ixtBrk, ixtRte, ixtSleep, ixtCpuid, ixtLdix
	} uIxtT;

	typedef enum logic [3:0] {
		fmtNone,
		fmtRegReg,
		fmtRegImmReg,
		fmtLdDisp,
		fmtStDisp,
		fmtRegPc,
		fmtPcDisp,
		fmtImm20Reg
	} fmtT;

	// operand layout within a format
	// sb plain, sw signed imm, ub upper imm, uw unsigned imm
	// ul csr write, uq csr read
	typedef enum logic [2:0] {
		layoutSb,
		layoutSw,
		layoutUb,
		layoutUw,
		layoutUl,
		layoutUq
	} layoutT;

	// instruction field positions
	localparam int opcodeLsb = 2;
	localparam int rdLsb = 7;
	localparam int funct3Lsb = 12;
	localparam int rs1Lsb = 15;
	localparam int rs2Lsb = 20;

endpackage

`default_nettype wire

//--- source/uopFieldsIf.sv
// micro-op command fields
// carries class, sub-operation, format and layout from the class decoder
// to the operand router and immediate unit
`default_nettype none

interface uopFieldsIf;
	decodePkg::uCmdT cmd;
	decodePkg::uIxtT ixt;
	decodePkg::fmtT fmt;
	decodePkg::layoutT layout;
	logic rdIsZero;

	modport producer (output cmd, ixt, fmt, layout, rdIsZero);
	modport consumer (input cmd, ixt, fmt, layout, rdIsZero);
endinterface

`default_nettype wire

//--- source/opClassDecode.sv
// class decoder
// maps opcode, funct3, funct7 and the system subfields to command class,
// sub-operation, format and operand layout
`default_nettype none

module opClassDecode (
	input wire decodePkg::instrWordT instrWord,
	uopFieldsIf.producer fields
);
	logic [4:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic rdZero;
	logic rs1Zero;
	logic csrIsCpuid;
	decodePkg::uCmdT aluCmd;
	decodePkg::uIxtT aluIxt;
	decodePkg::uCmdT cmd;
	decodePkg::uIxtT ixt;
	decodePkg::fmtT fmt;
	decodePkg::layoutT layout;

	assign opcode = instrWord[decodePkg::opcodeLsb +: 5];
	assign funct3 = instrWord[decodePkg::funct3Lsb +: 3];
	assign funct7 = instrWord[31:25];
	assign rdZero = (instrWord[decodePkg::rdLsb +: 5] == 5'd0);
	assign rs1Zero = (instrWord[decodePkg::rs1Lsb +: 5] == 5'd0);
	// csr 0xFC0-0xFFF
	assign csrIsCpuid = (instrWord[31:26] == 6'h3F);

	// alu and shift ops shared by op-imm and op
	always_comb begin
		aluCmd = decodePkg::cmdAlu3;
		case (funct3)
			3'b000: aluIxt = decodePkg::ixtAdd;
			3'b001: begin
				aluCmd = decodePkg::cmdShad3;
				aluIxt = decodePkg::ixtShl;
			end
			3'b010: aluIxt = decodePkg::ixtSltS;
			3'b011: aluIxt = decodePkg::ixtSltU;
			3'b100: aluIxt = decodePkg::ixtXor;
			3'b101: begin
				aluCmd = decodePkg::cmdShad3;
				aluIxt = instrWord[30] ? decodePkg::ixtShar : decodePkg::ixtShlr;
			end
			3'b110: aluIxt = decodePkg::ixtOr;
			default: aluIxt = decodePkg::ixtAnd;
		endcase
	end

	always_comb begin
		cmd = decodePkg::cmdInvOp;
		ixt = decodePkg::ixtAdd;
		fmt = decodePkg::fmtNone;
		layout = decodePkg::layoutSb;
		case (opcode)
			5'b00000: begin
				cmd = decodePkg::cmdMovMr;
				ixt = decodePkg::uIxtT'({3'b000, funct3});
				fmt = decodePkg::fmtLdDisp;
				layout = decodePkg::layoutUw;
			end
			5'b01000: begin
				cmd = decodePkg::cmdMovRm;
				ixt = decodePkg::uIxtT'({3'b000, funct3});
				fmt = decodePkg::fmtStDisp;
				layout = decodePkg::layoutSw;
			end
			5'b11000: begin
				cmd = decodePkg::cmdJcmp;
				fmt = decodePkg::fmtRegPc;
				case (funct3)
					3'b001: ixt = decodePkg::ixtNe;
					3'b100: ixt = decodePkg::ixtLt;
					3'b101: ixt = decodePkg::ixtGe;
					3'b110: ixt = decodePkg::ixtBl;
					3'b111: ixt = decodePkg::ixtHs;
					default: ixt = decodePkg::ixtEq;
				endcase
			end
			// jalr and jal drop the link when rd is x0
			5'b11001: begin
				cmd = rdZero ? decodePkg::cmdJmp : decodePkg::cmdJsr;
				fmt = decodePkg::fmtRegImmReg;
				layout = decodePkg::layoutSw;
			end
			5'b11011: begin
				cmd = rdZero ? decodePkg::cmdJmp : decodePkg::cmdJsr;
				fmt = decodePkg::fmtPcDisp;
				layout = decodePkg::layoutSw;
			end
			5'b00100: begin
				cmd = aluCmd;
				ixt = aluIxt;
				fmt = decodePkg::fmtRegImmReg;
				layout = decodePkg::layoutSw;
			end
			5'b01100: begin
				fmt = decodePkg::fmtRegReg;
				if (funct7 == 7'h01) begin
					cmd = decodePkg::cmdMulDiv;
					case (funct3)
						3'b000: ixt = decodePkg::ixtMul;
						3'b001: ixt = decodePkg::ixtMulhs;
						3'b010: ixt = decodePkg::ixtMulhsu;
						3'b011: ixt = decodePkg::ixtMulhu;
						3'b100: ixt = decodePkg::ixtDivs;
						3'b101: ixt = decodePkg::ixtDivu;
						3'b110: ixt = decodePkg::ixtMods;
						default: ixt = decodePkg::ixtModu;
					endcase
				end else begin
					cmd = aluCmd;
					ixt = (funct3 == 3'b000 && instrWord[30]) ? decodePkg::ixtSub : aluIxt;
				end
			end
			5'b01101: begin
				cmd = decodePkg::cmdMovIr;
				ixt = decodePkg::ixtLdix;
				fmt = decodePkg::fmtImm20Reg;
				layout = decodePkg::layoutUb;
			end
			5'b00101: begin
				cmd = decodePkg::cmdLeaMr;
				fmt = decodePkg::fmtPcDisp;
				layout = decodePkg::layoutUb;
			end
			5'b11100: begin
				case (funct3)
					3'b000: begin
						case (instrWord[23:20])
							4'h0: ixt = decodePkg::ixtSyse;
							4'h1: ixt = decodePkg::ixtBrk;
							4'h2: ixt = decodePkg::ixtRte;
							4'h5: ixt = decodePkg::ixtSleep;
							default: ixt = decodePkg::ixtAdd;
						endcase
						if (instrWord[23:20] inside {4'h0, 4'h1, 4'h2, 4'h5})
							cmd = decodePkg::cmdOpIxt;
					end
					3'b001: begin
						if (rdZero) begin
							cmd = decodePkg::cmdMovRc;
							fmt = decodePkg::fmtRegReg;
							layout = decodePkg::layoutUl;
						end
					end
					3'b010, 3'b011: begin
						if (rs1Zero) begin
							cmd = decodePkg::cmdMovCr;
							fmt = decodePkg::fmtRegReg;
							layout = decodePkg::layoutUq;
						end
						// cpuid wins over a plain csr read
						if (funct3 == 3'b010 && csrIsCpuid) begin
							cmd = decodePkg::cmdOpIxt;
							ixt = decodePkg::ixtCpuid;
							fmt = decodePkg::fmtRegReg;
							layout = decodePkg::layoutUq;
						end
					end
					default: begin
					end
				endcase
			end
			default: begin
			end
		endcase

		// only 32-bit encodings are legal here
		if (instrWord[1:0] != 2'b11) begin
			cmd = decodePkg::cmdInvOp;
			ixt = decodePkg::ixtAdd;
			fmt = decodePkg::fmtNone;
			layout = decodePkg::layoutSb;
		end
	end

	assign fields.cmd = cmd;
	assign fields.ixt = ixt;
	assign fields.fmt = fmt;
	assign fields.layout = layout;
	assign fields.rdIsZero = rdZero;

endmodule

`default_nettype wire

//--- source/regFieldMap.sv
// register field mapper
// turns rd, rs1, rs2 and the csr number into internal register ids
`default_nettype none

module regFieldMap (
	input wire decodePkg::instrWordT instrWord,
	output decodePkg::regIdT rdId,
	output decodePkg::regIdT rs1Id,
	output decodePkg::regIdT rs2Id,
	output decodePkg::regIdT csrId
);
	logic [11:0] csrNum;

	// low registers land on the core's special registers
	function automatic decodePkg::regIdT mapField(input logic [4:0] field);
		if (field[4])
			return {3'b000, field};
		case (field[3:0])
			4'd0: return decodePkg::regZzr;
			4'd1: return decodePkg::regLr;
			4'd2: return decodePkg::regSp;
			4'd3: return decodePkg::regGbr;
			4'd4: return decodePkg::regTbr;
			4'd5: return decodePkg::regDhr;
			4'd14: return decodePkg::regR2;
			4'd15: return decodePkg::regR3;
			// r6 to r13 keep their number
			default: return {4'b0000, field[3:0]};
		endcase
	endfunction

	assign rdId = mapField(instrWord[decodePkg::rdLsb +: 5]);
	assign rs1Id = mapField(instrWord[decodePkg::rs1Lsb +: 5]);
	assign rs2Id = mapField(instrWord[decodePkg::rs2Lsb +: 5]);

	// csr occupies the same bits as rs2 and funct7
	assign csrNum = instrWord[decodePkg::rs2Lsb +: 12];

	always_comb begin
		case (csrNum[11:6])
			6'h1F, 6'h2F, 6'h3F: csrId = decodePkg::regCrBase + {2'b00, csrNum[5:0]};
			default: csrId = decodePkg::regZzr;
		endcase
	end

endmodule

`default_nettype wire

//--- source/immExtract.sv
// immediate unit
// builds the I, S, B, J and U immediates and picks one by format and class
`default_nettype none

module immExtract (
	input wire decodePkg::instrWordT instrWord,
	uopFieldsIf.consumer fields,
	output decodePkg::immT imm
);
	decodePkg::immT iSigned;
	decodePkg::immT iUnsigned;
	decodePkg::immT sSigned;
	decodePkg::immT bHalf;
	decodePkg::immT jHalf;
	decodePkg::immT uUpper;

	assign iSigned = {{21{instrWord[31]}}, instrWord[31:20]};
	assign iUnsigned = {21'd0, instrWord[31:20]};
	assign sSigned = {{21{instrWord[31]}}, instrWord[31:25], instrWord[11:7]};
	// branch and jump offsets are kept in halfwords
	assign bHalf = {{21{instrWord[31]}}, instrWord[31], instrWord[7],
		instrWord[30:25], instrWord[11:8]};
	assign jHalf = {{13{instrWord[31]}}, instrWord[31], instrWord[19:12],
		instrWord[20], instrWord[30:21]};
	assign uUpper = {1'b0, instrWord[31:12], 12'h000};

	always_comb begin
		imm = '0;
		case (fields.fmt)
			decodePkg::fmtRegImmReg, decodePkg::fmtLdDisp:
				imm = (fields.layout == decodePkg::layoutUw) ? iUnsigned : iSigned;
			decodePkg::fmtStDisp: imm = sSigned;
			decodePkg::fmtRegPc: imm = bHalf;
			// auipc shares the pc format with jal
			decodePkg::fmtPcDisp:
				imm = (fields.cmd == decodePkg::cmdLeaMr) ? uUpper : jHalf;
			decodePkg::fmtImm20Reg: imm = uUpper;
			default: imm = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- source/operandRoute.sv
// operand router
// places mapped register ids, BPC, IMM or ZZR into the N, M, O and P slots
// by format and layout
`default_nettype none

module operandRoute (
	uopFieldsIf.consumer fields,
	input wire decodePkg::regIdT rdId,
	input wire decodePkg::regIdT rs1Id,
	input wire decodePkg::regIdT rs2Id,
	input wire decodePkg::regIdT csrId,
	output decodePkg::regIdT regN,
	output decodePkg::regIdT regM,
	output decodePkg::regIdT regO,
	output decodePkg::regIdT regP
);
	always_comb begin
		regN = decodePkg::regZzr;
		regM = decodePkg::regZzr;
		regO = decodePkg::regZzr;
		case (fields.fmt)
			decodePkg::fmtRegReg: begin
				case (fields.layout)
					// csr write, source into control register
					decodePkg::layoutUl: begin
						regN = csrId;
						regM = rs1Id;
					end
					// csr read and cpuid
					decodePkg::layoutUq: begin
						regN = rdId;
						regM = csrId;
					end
					default: begin
						regN = rdId;
						regM = rs1Id;
						regO = rs2Id;
					end
				endcase
			end
			decodePkg::fmtRegImmReg, decodePkg::fmtLdDisp: begin
				regN = rdId;
				regM = rs1Id;
				regO = decodePkg::regImm;
			end
			// store data goes out through N
			decodePkg::fmtStDisp: begin
				regN = rs2Id;
				regM = rs1Id;
				regO = decodePkg::regImm;
			end
			decodePkg::fmtRegPc: begin
				regM = rs1Id;
				regO = rs2Id;
			end
			decodePkg::fmtPcDisp: begin
				regN = rdId;
				regM = decodePkg::regBpc;
				regO = decodePkg::regImm;
			end
			decodePkg::fmtImm20Reg: begin
				regN = rdId;
				regM = rdId;
				regO = decodePkg::regImm;
			end
			default: begin
			end
		endcase
	end

	assign regP = regN;

endmodule

`default_nettype wire

//--- source/rvDecodeStage.sv
// rv32 decode stage
// decodes one instruction word per cycle into a micro-op and registers it
// with its valid flag, one cycle of latency
`default_nettype none

module rvDecodeStage (
	input wire clock,
	input wire reset,
	input wire instrValid,
	input wire decodePkg::instrWordT instrWord,
	output logic uopValid,
	output decodePkg::uCmdT uCmd,
	output decodePkg::uIxtT uIxt,
	output decodePkg::regIdT regN,
	output decodePkg::regIdT regM,
	output decodePkg::regIdT regO,
	output decodePkg::regIdT regP,
	output decodePkg::immT imm
);
	uopFieldsIf uopFields ();

	decodePkg::regIdT rdId;
	decodePkg::regIdT rs1Id;
	decodePkg::regIdT rs2Id;
	decodePkg::regIdT csrId;
	decodePkg::regIdT nextN;
	decodePkg::regIdT nextM;
	decodePkg::regIdT nextO;
	decodePkg::regIdT nextP;
	decodePkg::immT nextImm;

	opClassDecode classDecode (
		.instrWord(instrWord),
		.fields(uopFields.producer)
	);

	regFieldMap fieldMap (
		.instrWord(instrWord),
		.rdId(rdId),
		.rs1Id(rs1Id),
		.rs2Id(rs2Id),
		.csrId(csrId)
	);

	immExtract immUnit (
		.instrWord(instrWord),
		.fields(uopFields.consumer),
		.imm(nextImm)
	);

	operandRoute router (
		.fields(uopFields.consumer),
		.rdId(rdId),
		.rs1Id(rs1Id),
		.rs2Id(rs2Id),
		.csrId(csrId),
		.regN(nextN),
		.regM(nextM),
		.regO(nextO),
		.regP(nextP)
	);

	// fields hold their last value on idle cycles
	always_ff @(posedge clock) begin
		if (reset) begin
			uopValid <= 1'b0;
			uCmd <= decodePkg::cmdInvOp;
			uIxt <= decodePkg::ixtAdd;
			regN <= decodePkg::regZzr;
			regM <= decodePkg::regZzr;
			regO <= decodePkg::regZzr;
			regP <= decodePkg::regZzr;
			imm <= '0;
		end else begin
			uopValid <= instrValid;
			if (instrValid) begin
				uCmd <= uopFields.cmd;
				uIxt <= uopFields.ixt;
				regN <= nextN;
				regM <= nextM;
				regO <= nextO;
				regP <= nextP;
				imm <= nextImm;
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/decodeTb.sv
// testbench for the rv32 decode stage
// replays instruction words from the stimulus file and checks each
// micro-op one cycle after issue, with random idle gaps between words
`default_nettype none

module decodeTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int resetCycles = 8;
	localparam int fieldsPerRecord = 7;
	localparam int memDepth = 512;
	localparam int maxGap = 1;
	localparam int drainCycles = 3;

	logic clock;
	logic reset;
	logic instrValid;
	decodePkg::instrWordT instrWord;
	logic uopValid;
	decodePkg::uCmdT uCmd;
	decodePkg::uIxtT uIxt;
	decodePkg::regIdT regN;
	decodePkg::regIdT regM;
	decodePkg::regIdT regO;
	decodePkg::regIdT regP;
	decodePkg::immT imm;

	// one hex token per entry, bit 33 set means never written
	logic [33:0] stimMem [0:memDepth-1];
	int recordCount;
	int cycleCount = 0;
	int cycleLimit;
	int edgeCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int errorCount = 0;
	logic [15:0] lfsrState;
	// issued words waiting for their micro-op
	int pendingIdx[$];
	int pendingEdge[$];

	rvDecodeStage dut (
		.clock(clock),
		.reset(reset),
		.instrValid(instrValid),
		.instrWord(instrWord),
		.uopValid(uopValid),
		.uCmd(uCmd),
		.uIxt(uIxt),
		.regN(regN),
		.regM(regM),
		.regO(regO),
		.regP(regP),
		.imm(imm)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout: run still going after %0d cycles", cycleCount);
			$display("Test failures found");
			$finish;
		end
	end

	// galois lfsr, one step per bit taken
	function automatic logic takeBit();
		logic bit0;
		bit0 = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (bit0)
			lfsrState = lfsrState ^ 16'hB400;
		return bit0;
	endfunction

	task automatic loadStimulus();
		int a;
		int last;
		last = -1;
		for (a = 0; a < memDepth; a++)
			stimMem[a] = {1'b1, 33'(a)};
		$readmemh("tests/decodeStimulus.hex", stimMem);
		for (a = 0; a < memDepth; a++)
			if (!stimMem[a][33])
				last = a;
		recordCount = 0;
		if (last < 0) begin
			$display("stimulus file is missing or holds no entries");
			errorCount++;
		end else begin
			recordCount = int'(stimMem[last][31:0]);
			if (recordCount * fieldsPerRecord != last) begin
				$display("record count %0d does not match %0d entries", recordCount, last);
				errorCount++;
				recordCount = last / fieldsPerRecord;
			end
		end
	endtask

	task automatic compareField(input string name, input logic [32:0] actual,
		input logic [32:0] expected, inout int fails);
		if (actual !== expected) begin
			$display("FAIL %s: got %0h, expected %0h", name, actual, expected);
			fails++;
		end
	endtask

	task automatic checkOutputs();
		int idx;
		int base;
		int fails;
		fails = 0;
		if (pendingEdge.size() != 0 && pendingEdge[0] == edgeCount - 1) begin
			idx = pendingIdx.pop_front();
			void'(pendingEdge.pop_front());
			base = idx * fieldsPerRecord;
			if (uopValid !== 1'b1) begin
				$display("no uopValid one cycle after issuing test %0d", idx + 1);
				fails++;
			end else begin
				compareField("uCmd", {27'd0, uCmd}, stimMem[base + 1][32:0], fails);
				compareField("uIxt", {27'd0, uIxt}, stimMem[base + 2][32:0], fails);
				compareField("regN", {25'd0, regN}, stimMem[base + 3][32:0], fails);
				compareField("regM", {25'd0, regM}, stimMem[base + 4][32:0], fails);
				compareField("regO", {25'd0, regO}, stimMem[base + 5][32:0], fails);
				// P mirrors N
				compareField("regP", {25'd0, regP}, stimMem[base + 3][32:0], fails);
				compareField("imm", imm, stimMem[base + 6][32:0], fails);
			end
			testsRun++;
			errorCount += fails;
			if (fails == 0) begin
				$display("test %2d  word %08h  ok", idx + 1, stimMem[base][31:0]);
			end else begin
				$display("test %2d  word %08h  failed", idx + 1, stimMem[base][31:0]);
				testsFailed++;
			end
		end else if (uopValid !== 1'b0) begin
			$display("uopValid high at cycle %0d with no word issued before it", edgeCount);
			errorCount++;
		end
	endtask

	// drive at the rising edge, check at the falling edge
	task automatic runCycle(input logic issue, input int recordIdx);
		@(posedge clock);
		edgeCount++;
		instrValid <= issue;
		if (issue) begin
			instrWord <= stimMem[recordIdx * fieldsPerRecord][31:0];
			pendingIdx.push_back(recordIdx);
			pendingEdge.push_back(edgeCount);
		end
		@(negedge clock);
		checkOutputs();
	endtask

	initial begin
		int c;
		int t;
		int fails;
		reset = 1'b1;
		instrValid = 1'b0;
		instrWord = '0;
		lfsrState = 16'd44;
		loadStimulus();
		cycleLimit = recordCount * (1 + maxGap) + resetCycles + drainCycles + 2;

		fails = 0;
		for (c = 0; c < resetCycles; c++) begin
			@(posedge clock);
			if (c == resetCycles - 1)
				reset <= 1'b0;
			@(negedge clock);
			if (uopValid !== 1'b0) begin
				$display("uopValid not low in reset cycle %0d", c + 1);
				fails++;
			end
		end
		compareField("uCmd", {27'd0, uCmd}, 33'h0, fails);
		compareField("regN", {25'd0, regN}, 33'h20, fails);
		compareField("regM", {25'd0, regM}, 33'h20, fails);
		compareField("regO", {25'd0, regO}, 33'h20, fails);
		compareField("regP", {25'd0, regP}, 33'h20, fails);
		compareField("imm", imm, 33'h0, fails);
		testsRun++;
		errorCount += fails;
		if (fails == 0) begin
			$display("reset state  ok");
		end else begin
			$display("reset state  failed");
			testsFailed++;
		end

		for (t = 0; t < recordCount; t++) begin
			// some words back to back, some after one idle cycle
			if (takeBit())
				runCycle(1'b0, 0);
			runCycle(1'b1, t);
		end
		for (c = 0; c < drainCycles; c++)
			runCycle(1'b0, 0);

		$display("%0d tests run, %0d passed, %0d failed, %0d errors", testsRun,
			testsRun - testsFailed, testsFailed, errorCount);
		if (errorCount == 0 && recordCount > 0 && testsRun == recordCount + 1) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/decodeStimulus.hex
// word     cmd ixt regN regM regO imm
// one record per line, the last line holds the record count
// op-imm alu and shifts
7FFA8A13 01 00 14 15 27 0000007FF
FFF08393 01 00 07 21 27 1FFFFFFFF
80012913 01 02 12 22 27 1FFFFF800
0F024513 01 04 0A 24 27 0000000F0
00329593 02 07 0B 25 27 000000003
40735613 02 09 0C 06 27 000000407
00275693 02 08 0D 02 27 000000002
FF0FF793 01 06 03 1F 27 1FFFFFFF0
// register forms and multiply/divide
41288833 01 01 10 11 12 000000000
0020E9B3 01 05 13 21 22 000000000
416ADA33 02 09 14 15 16 000000000
02A4A433 03 0C 08 09 0A 000000000
039C7BB3 03 11 17 18 19 000000000
// load unsigned imm, stores signed with rs2 in N
FFC12283 04 02 25 22 27 000000FFC
FFCEAC23 05 02 1C 1D 27 1FFFFFFF8
06118FA3 05 00 21 23 27 00000007F
// branches and jumps, offsets in halfwords
FF1818E3 06 13 20 10 11 1FFFFFFF8
007370E3 06 17 20 06 07 000000400
00F04263 06 14 20 20 03 000000002
00942063 06 12 20 08 09 000000000
FFDFF0EF 07 00 21 26 27 1FFFFFFFE
1000006F 08 00 20 26 27 000000080
00008067 08 00 20 21 27 000000000
FF4A02E7 07 00 25 14 27 1FFFFFFF4
// lui and auipc
ABCDE4B7 0A 1D 09 09 27 0ABCDE000
80000117 09 00 22 26 27 080000000
// system, csr access, cpuid
00000073 0D 18 20 20 20 000000000
00100073 0D 19 20 20 20 000000000
30200073 0D 1A 20 20 20 000000000
10500073 0D 1B 20 20 20 000000000
7C531073 0B 00 45 06 20 000000000
BFF02573 0C 00 0A 7F 20 000000000
300031F3 0C 00 23 20 20 000000000
FC3028F3 0D 1C 11 43 20 000000000
// bad low bits, unknown opcode
7FFA8A10 00 00 20 20 20 000000000
1234560B 00 00 20 20 20 000000000
24

//--- files.f
source/decodePkg.sv
source/uopFieldsIf.sv
source/opClassDecode.sv
source/regFieldMap.sv
source/immExtract.sv
source/operandRoute.sv
source/rvDecodeStage.sv
tests/decodeTb.sv

//--- Makefile
# Verilator build and run for the rv32 decode stage

SOURCES = $(shell cat files.f)

obj_dir/VdecodeTb: files.f $(SOURCES)
	verilator --binary --timing --timescale 1ns/1ps -f files.f --top-module decodeTb -Mdir obj_dir

run: obj_dir/VdecodeTb
	obj_dir/VdecodeTb | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
